/* hdl/addr_sequencer.sv */
`timescale 1ns/1ps
`include "bist_consts.svh"

module addr_sequencer
  import bist_pkg::*;
(
  input  logic        testclk,
  input  logic        reset,
  input  march_ctrl_t cmd,
  output slot_t       slot,
  output logic        pass_end
);

  localparam logic [`BIST_ADDR_W-1:0] LAST_ADDR = `BIST_ADDR_W'(`BIST_DEPTH - 1);

  logic                    active;
  logic                    phase;
  logic [`BIST_ADDR_W-1:0] addr;
  logic                    at_end;
  logic                    slot_last;

  // Terminal address depends on the direction of the current element
  assign at_end = cmd.up ? (addr == LAST_ADDR) : (addr == '0);

  // In a read element the write slot (phase 1) closes the address
  assign slot_last = at_end && (!cmd.checken || phase);

  always_ff @(posedge testclk)
  begin
    if (reset)
    begin
      active <= 1'b0;
      phase  <= 1'b0;
      addr   <= '0;
    end
    else if (!cmd.run)
    begin
      active <= 1'b0;
      phase  <= 1'b0;
    end
    else if (cmd.clr)
    begin
      active <= 1'b1;
      phase  <= 1'b0;
      addr   <= cmd.up ? '0 : LAST_ADDR;
    end
    else if (active)
    begin
      if (cmd.checken && !phase)
      begin
        phase <= 1'b1;
      end
      else
      begin
        phase <= 1'b0;
        if (at_end)
          active <= 1'b0;
        else if (cmd.up)
          addr <= addr + 1'b1;
        else
          addr <= addr - 1'b1;
      end
    end
  end

  // Slots stop in the same cycle that the controller drops run
  assign slot.valid  = active && cmd.run;
  assign slot.addr   = addr;
  assign slot.rd     = cmd.checken && !phase;
  assign slot.dinsel = cmd.dinsel;

  assign pass_end = slot.valid && slot_last;

  // Every read slot is followed by the write slot of the same address unless the run stops
  a_read_then_write: assert property (@(posedge testclk) disable iff (reset)
    (slot.valid && slot.rd) |=> (!cmd.run || (slot.valid && !slot.rd &&
      (slot.addr == $past(slot.addr)))));

endmodule

/* hdl/bist_consts.svh */
`ifndef BIST_CONSTS_SVH
`define BIST_CONSTS_SVH

// Address width of the RAM under test
`define BIST_ADDR_W 4

// Data width of one RAM word
`define BIST_DATA_W 8

// Number of words covered by one march pass
`define BIST_DEPTH (1 << `BIST_ADDR_W)

`endif

/* hdl/bist_pkg.sv */
`include "bist_consts.svh"

package bist_pkg;

  // Command from the march FSM to the address sequencer
  typedef struct packed {
    logic clr;
    logic up;
    logic dinsel;
    logic checken;
    logic run;
  } march_ctrl_t;

  // One step of a pass, either a read slot or a write slot
  typedef struct packed {
    logic                    valid;
    logic [`BIST_ADDR_W-1:0] addr;
    logic                    rd;
    logic                    dinsel;
  } slot_t;

  // Request on the single RAM port
  typedef struct packed {
    logic                    en;
    logic                    we;
    logic [`BIST_ADDR_W-1:0] addr;
    logic [`BIST_DATA_W-1:0] wdata;
  } ram_req_t;

  // Expected data for a read that is in flight
  typedef struct packed {
    logic                    valid;
    logic [`BIST_ADDR_W-1:0] addr;
    logic [`BIST_DATA_W-1:0] exp_data;
  } chk_t;

  // Result of the last run, kept after the run ends or is aborted
  typedef struct packed {
    logic                    done;
    logic                    fail;
    logic [`BIST_ADDR_W-1:0] fail_addr;
    logic [7:0]              err_count;
  } bist_status_t;

endpackage

/* hdl/march_cntrl.sv */
`timescale 1ns/1ps

module march_cntrl
  import bist_pkg::*;
(
  input  logic        testclk,
  input  logic        reset,
  input  logic        test,
  input  logic        pass_end,
  output march_ctrl_t cmd,
  output logic        march_done
);

  // One state per march element plus idle and done
  localparam logic [2:0] IDLE     = 3'b000;
  localparam logic [2:0] BACK0    = 3'b001;
  localparam logic [2:0] FWD_R0W1 = 3'b010;
  localparam logic [2:0] REV_R1W0 = 3'b011;
  localparam logic [2:0] BACK1    = 3'b100;
  localparam logic [2:0] FWD_R1W0 = 3'b101;
  localparam logic [2:0] REV_R0W1 = 3'b110;
  localparam logic [2:0] DONE     = 3'b111;

  logic [2:0] state;
  logic [2:0] next_state;
  logic       clr_q;

  // A low test forces idle from any state, which is how a run is aborted
  always_comb
  begin
    next_state = state;
    if (!test)
    begin
      next_state = IDLE;
    end
    else
    begin
      case (state)
        IDLE:     next_state = BACK0;
        BACK0:    if (pass_end) next_state = FWD_R0W1;
        FWD_R0W1: if (pass_end) next_state = REV_R1W0;
        REV_R1W0: if (pass_end) next_state = BACK1;
        BACK1:    if (pass_end) next_state = FWD_R1W0;
        FWD_R1W0: if (pass_end) next_state = REV_R0W1;
        REV_R0W1: if (pass_end) next_state = DONE;
        default:  next_state = DONE;
      endcase
    end
  end

  // The clear pulse goes out together with the first cycle of each element
  always_ff @(posedge testclk)
  begin
    if (reset)
    begin
      state <= IDLE;
      clr_q <= 1'b0;
    end
    else
    begin
      state <= next_state;
      clr_q <= (next_state != state) && (next_state != IDLE) && (next_state != DONE);
    end
  end

  // In read elements the expected value is the complement of dinsel
  always_comb
  begin
    cmd.clr     = clr_q;
    cmd.run     = (state != IDLE) && (state != DONE);
    cmd.up      = 1'b1;
    cmd.dinsel  = 1'b0;
    cmd.checken = 1'b0;
    case (state)
      FWD_R0W1:
      begin
        cmd.dinsel  = 1'b1;
        cmd.checken = 1'b1;
      end
      REV_R1W0:
      begin
        cmd.up      = 1'b0;
        cmd.checken = 1'b1;
      end
      BACK1:
      begin
        cmd.dinsel = 1'b1;
      end
      FWD_R1W0:
      begin
        cmd.checken = 1'b1;
      end
      REV_R0W1:
      begin
        cmd.up      = 1'b0;
        cmd.dinsel  = 1'b1;
        cmd.checken = 1'b1;
      end
      default:
      begin
        cmd.up = 1'b1;
      end
    endcase
  end

  assign march_done = (state == DONE);

  // The sequencer cannot end a pass in the clear cycle that starts an element
  a_pass_after_clr: assert property (@(posedge testclk) disable iff (reset)
    pass_end |-> !cmd.clr);

endmodule

/* hdl/pattern_gen.sv */
`timescale 1ns/1ps
`include "bist_consts.svh"

module pattern_gen
  import bist_pkg::*;
(
  input  logic     testclk,
  input  logic     reset,
  input  slot_t    slot,
  output ram_req_t ram_req,
  output chk_t     chk
);

  logic                    en_q;
  logic                    we_q;
  logic                    chk_valid_q;
  logic [`BIST_ADDR_W-1:0] addr_q;
  logic [`BIST_DATA_W-1:0] wdata_q;
  logic [`BIST_DATA_W-1:0] exp_q;

  // Strobes for the RAM port and the checker
  always_ff @(posedge testclk)
  begin
    if (reset)
    begin
      en_q        <= 1'b0;
      we_q        <= 1'b0;
      chk_valid_q <= 1'b0;
    end
    else
    begin
      en_q        <= slot.valid;
      we_q        <= slot.valid && !slot.rd;
      chk_valid_q <= slot.valid && slot.rd;
    end
  end

  // The background bit fills the whole word; a read expects its complement
  always_ff @(posedge testclk)
  begin
    addr_q  <= slot.addr;
    wdata_q <= {`BIST_DATA_W{slot.dinsel}};
    exp_q   <= {`BIST_DATA_W{~slot.dinsel}};
  end

  assign ram_req.en    = en_q;
  assign ram_req.we    = we_q;
  assign ram_req.addr  = addr_q;
  assign ram_req.wdata = wdata_q;

  // Same register stage as the request, so the two stay aligned
  assign chk.valid    = chk_valid_q;
  assign chk.addr     = addr_q;
  assign chk.exp_data = exp_q;

endmodule

/* hdl/ram_bist_top.sv */
`timescale 1ns/1ps
`include "bist_consts.svh"

module ram_bist_top
  import bist_pkg::*;
(
  input  logic                    testclk,
  input  logic                    reset,
  input  logic                    test,
  output ram_req_t                ram_req,
  input  logic [`BIST_DATA_W-1:0] rdata,
  output bist_status_t            status
);

  march_ctrl_t cmd;
  slot_t       slot;
  chk_t        chk;
  logic        pass_end;
  logic        march_done;

  // Sequences the six march elements
  march_cntrl u_march_cntrl (
    .testclk    (testclk),
    .reset      (reset),
    .test       (test),
    .pass_end   (pass_end),
    .cmd        (cmd),
    .march_done (march_done)
  );

  // Walks the addresses of one element
  addr_sequencer u_addr_sequencer (
    .testclk  (testclk),
    .reset    (reset),
    .cmd      (cmd),
    .slot     (slot),
    .pass_end (pass_end)
  );

  pattern_gen u_pattern_gen (
    .testclk (testclk),
    .reset   (reset),
    .slot    (slot),
    .ram_req (ram_req),
    .chk     (chk)
  );

  // Compares the returned words and holds the result
  response_checker u_response_checker (
    .testclk    (testclk),
    .reset      (reset),
    .test       (test),
    .chk        (chk),
    .rdata      (rdata),
    .march_done (march_done),
    .status     (status)
  );

endmodule

/* hdl/response_checker.sv */
`timescale 1ns/1ps
`include "bist_consts.svh"

module response_checker
  import bist_pkg::*;
(
  input  logic                    testclk,
  input  logic                    reset,
  input  logic                    test,
  input  chk_t                    chk,
  input  logic [`BIST_DATA_W-1:0] rdata,
  input  logic                    march_done,
  output bist_status_t            status
);

  logic test_q;
  logic start;
  chk_t chk_d;
  logic mismatch;
  logic drained;

  assign start = test && !test_q;

  // Read data comes back one cycle after the request, so the record waits one cycle
  always_ff @(posedge testclk)
  begin
    if (reset)
    begin
      test_q      <= 1'b0;
      chk_d.valid <= 1'b0;
    end
    else
    begin
      test_q      <= test;
      chk_d.valid <= chk.valid && test && !start;
    end
  end

  always_ff @(posedge testclk)
  begin
    chk_d.addr     <= chk.addr;
    chk_d.exp_data <= chk.exp_data;
  end

  assign mismatch = chk_d.valid && (rdata != chk_d.exp_data);
  assign drained  = !chk.valid && !chk_d.valid;

  always_ff @(posedge testclk)
  begin
    if (reset || start)
    begin
      status <= '0;
    end
    else
    begin
      if (march_done && drained)
        status.done <= 1'b1;
      if (mismatch)
      begin
        status.fail <= 1'b1;
        // Only the first failing address is recorded
        if (!status.fail)
          status.fail_addr <= chk_d.addr;
        if (status.err_count != 8'hff)
          status.err_count <= status.err_count + 8'd1;
      end
    end
  end

  // No compare may still be in flight once done is reported
  a_done_drained: assert property (@(posedge testclk) disable iff (reset)
    status.done |-> (!chk.valid && !chk_d.valid));

endmodule

/* ram_bist_top.f */
+incdir+hdl
hdl/bist_pkg.sv
hdl/march_cntrl.sv
hdl/addr_sequencer.sv
hdl/pattern_gen.sv
hdl/response_checker.sv
hdl/ram_bist_top.sv
verif/sram_model.sv
verif/tb_ram_bist_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile the BIST engine with its testbench and run it; the exit status is the result

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
  -f ram_bist_top.f \
  --top-module tb_ram_bist_top \
  -o sim_tb &&
./obj_dir/sim_tb ||
{ echo "Build or simulation returned an error status"; exit 1; }

/* verif/sram_model.sv */
`timescale 1ns/1ps
`include "bist_consts.svh"

module sram_model
  import bist_pkg::*;
(
  input  logic                            testclk,
  input  ram_req_t                        ram_req,
  input  logic                            stuck_en,
  input  logic [`BIST_ADDR_W-1:0]         stuck_addr,
  input  logic [$clog2(`BIST_DATA_W)-1:0] stuck_bit,
  input  logic                            stuck_val,
  output logic [`BIST_DATA_W-1:0]         rdata
);

  logic [`BIST_DATA_W-1:0] mem [`BIST_DEPTH];
  logic [`BIST_DATA_W-1:0] word;

  // The faulty cell reads back its stuck value whatever was written to it
  always_comb
  begin
    word = mem[ram_req.addr];
    if (stuck_en && (ram_req.addr == stuck_addr))
      word[stuck_bit] = stuck_val;
  end

  // One-cycle read latency, writes take effect at the edge
  always_ff @(posedge testclk)
  begin
    if (ram_req.en)
    begin
      if (ram_req.we)
        mem[ram_req.addr] <= ram_req.wdata;
      else
        rdata <= word;
    end
  end

endmodule

/* verif/tb_ram_bist_top.sv */
`timescale 1ns/1ps
`include "bist_consts.svh"

module tb_ram_bist_top
  import bist_pkg::*;
();

  // Bit i of each table belongs to march element i
  localparam logic [5:0] EL_UP = 6'b011011;
  localparam logic [5:0] EL_BG = 6'b101010;
  localparam logic [5:0] EL_RD = 6'b110110;
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int BIT_W = $clog2(`BIST_DATA_W);

  logic                    testclk = 1'b0;
  logic                    reset;
  logic                    test;
  logic                    stuck_en;
  logic [`BIST_ADDR_W-1:0] stuck_addr;
  logic [BIT_W-1:0]        stuck_bit;
  logic                    stuck_val;
  logic                    mon_on;
  logic [31:0]             seed;
  logic [`BIST_DATA_W-1:0] rdata;
  ram_req_t                ram_req;
  bist_status_t            status;
  ram_req_t                exp_reqs[$];

  ram_bist_top DUT (
    .testclk (testclk),
    .reset   (reset),
    .test    (test),
    .ram_req (ram_req),
    .rdata   (rdata),
    .status  (status)
  );

  sram_model u_sram (
    .testclk    (testclk),
    .ram_req    (ram_req),
    .stuck_en   (stuck_en),
    .stuck_addr (stuck_addr),
    .stuck_bit  (stuck_bit),
    .stuck_val  (stuck_val),
    .rdata      (rdata)
  );

  always #50 testclk = ~testclk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  // The address is a don't care when idle and the write data only matters on a write
  task automatic check_req(input ram_req_t act, input ram_req_t exp);
    logic bad;
    bad = (act.en !== exp.en) || (act.we !== exp.we);
    if (exp.en && (act.addr !== exp.addr))
      bad = 1'b1;
    if (exp.we && (act.wdata !== exp.wdata))
      bad = 1'b1;
    if (bad)
      fail_run($sformatf("FAILED at %0t: ram_req en=%0b we=%0b addr=%0h wdata=%0h, %s",
        $time, act.en, act.we, act.addr, act.wdata,
        $sformatf("expected en=%0b we=%0b addr=%0h wdata=%0h",
          exp.en, exp.we, exp.addr, exp.wdata)));
  endtask

  task automatic check_status(input bist_status_t act, input bist_status_t exp,
                              input string what);
    if (act !== exp)
      fail_run($sformatf("FAILED at %0t: %s status done=%0b fail=%0b addr=%0h err=%0d, %s",
        $time, what, act.done, act.fail, act.fail_addr, act.err_count,
        $sformatf("expected done=%0b fail=%0b addr=%0h err=%0d",
          exp.done, exp.fail, exp.fail_addr, exp.err_count)));
  endtask

  // Every enabled request must match the next one predicted by the march
  always @(negedge testclk)
  begin
    ram_req_t exp;
    if (mon_on && ram_req.en)
    begin
      if (exp_reqs.size() == 0)
        fail_run($sformatf("RAM request at %0t came after the march should have ended", $time));
      exp = exp_reqs.pop_front();
      check_req(ram_req, exp);
    end
  end

  task automatic build_march_queue();
    ram_req_t r;
    int       a;
    exp_reqs.delete();
    for (int e = 0; e < 6; e++)
    begin
      for (int i = 0; i < `BIST_DEPTH; i++)
      begin
        a = EL_UP[e] ? i : (`BIST_DEPTH - 1 - i);
        r.en    = 1'b1;
        r.addr  = `BIST_ADDR_W'(a);
        r.wdata = {`BIST_DATA_W{EL_BG[e]}};
        if (EL_RD[e])
        begin
          r.we = 1'b0;
          exp_reqs.push_back(r);
        end
        r.we = 1'b1;
        exp_reqs.push_back(r);
      end
    end
  endtask

  // A read expects the complement of its element's background
  function automatic logic [7:0] expected_errors(input logic stuck_value);
    logic [7:0] n;
    n = 8'd0;
    for (int e = 0; e < 6; e++)
      if (EL_RD[e] && ((~EL_BG[e]) != stuck_value))
        n = n + 8'd1;
    return n;
  endfunction

  task automatic run_march(input bist_status_t exp_status, input string what);
    int cycles;
    build_march_queue();
    @(posedge testclk);
    #1;
    mon_on = 1'b1;
    test   = 1'b1;
    // The previous status is cleared on the first edge with test high
    repeat (2) @(negedge testclk);
    cycles = 0;
    while (status.done !== 1'b1)
    begin
      @(negedge testclk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES)
        fail_run($sformatf("Timed out waiting for status.done in the %s", what));
    end
    if (exp_reqs.size() != 0)
      fail_run($sformatf("The %s finished with %0d RAM requests never issued",
        what, exp_reqs.size()));
    check_status(status, exp_status, what);
    @(posedge testclk);
    #1;
    test = 1'b0;
    repeat (3) @(posedge testclk);
    #1;
    mon_on = 1'b0;
  endtask

  task automatic idle_after_reset();
    @(negedge testclk);
    check_req(ram_req, '0);
    check_status(status, '0, "post-reset");
  endtask

  task automatic fault_free_march();
    bist_status_t exp;
    exp      = '0;
    exp.done = 1'b1;
    run_march(exp, "fault-free run");
  endtask

  task automatic stuck_bit_march();
    bist_status_t exp;
    seed = lcg_next(seed);
    stuck_addr = `BIST_ADDR_W'(seed[31:16] % `BIST_DEPTH);
    seed = lcg_next(seed);
    stuck_bit = BIT_W'(seed[31:16] % `BIST_DATA_W);
    stuck_val = seed[31];
    stuck_en  = 1'b1;
    exp           = '0;
    exp.done      = 1'b1;
    exp.fail      = 1'b1;
    exp.fail_addr = stuck_addr;
    exp.err_count = expected_errors(stuck_val);
    run_march(exp, "stuck-at run");
    stuck_en = 1'b0;
  endtask

  task automatic abort_and_rerun();
    bist_status_t exp;
    @(posedge testclk);
    #1;
    test = 1'b1;
    repeat (40) @(posedge testclk);
    #1;
    test = 1'b0;
    // One request may still leave the output register after the abort
    repeat (2) @(posedge testclk);
    for (int n = 0; n < 40; n++)
    begin
      @(negedge testclk);
      if (ram_req.en)
        fail_run("The RAM was still being accessed after test was lowered");
    end
    check_status(status, '0, "aborted run");
    exp      = '0;
    exp.done = 1'b1;
    run_march(exp, "rerun after abort");
  endtask

  initial
  begin
    reset      = 1'b1;
    test       = 1'b0;
    stuck_en   = 1'b0;
    stuck_addr = '0;
    stuck_bit  = '0;
    stuck_val  = 1'b0;
    mon_on     = 1'b0;
    seed       = 32'h75cb_d8eb;
    repeat (3) @(posedge testclk);
    #1;
    reset = 1'b0;
    idle_after_reset();
    fault_free_march();
    stuck_bit_march();
    abort_and_rerun();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule
